//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// register file
`define REG_ADDR_BITS 3 // 8 registers.
`define NUM_REGS (1 << `REG_ADDR_BITS)

// datapath
`define DATA_BITS 16
`define IMM_BITS 8 // zero-extended.

// data memory
`define DMEM_ADDR_BITS 4 // addresses wrap.
`define DMEM_WORDS (1 << `DMEM_ADDR_BITS)

// instruction encoding
`define OP_CODE_BITS 6

// pipeline control
`define NUM_PIPE_MASKS 3 // pc, if_id, id_ex.

`endif

//--- verilog/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef logic [`DATA_BITS-1:0] data_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`DMEM_ADDR_BITS-1:0] dmem_addr_t;

  // top two bits select the group.
  typedef enum logic [`OP_CODE_BITS-1:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_ADDI = 6'h10,
    OP_ANDI = 6'h11,
    OP_LW   = 6'h20,
    OP_SW   = 6'h21
  } opcode_e;

  typedef struct packed {
    logic [`OP_CODE_BITS-1:0] opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [`IMM_BITS-1:0] imm;
  } instr_t;

  typedef struct packed {
    instr_t [1:0] slot;
    logic first; // slot 0 is older.
  } pair_t;

  typedef struct packed {
    logic pc;
    logic if_id;
    logic id_ex;
  } pipe_mask_t;

  typedef struct packed {
    logic src_rs;
    logic src_rt;
    logic dst_rt;
    logic dst_rd;
    logic mem_read;
    logic mem_write;
    instr_t instr;
  } dec_t;

  typedef struct packed {
    logic valid;
    dec_t dec;
  } slot_t;

  typedef slot_t [1:0] slot_pair_t; // lane 0 holds the older slot.

  typedef struct packed {
    logic valid;
    reg_addr_t dst;
    data_t data;
  } wb_t;

  typedef struct packed {
    logic valid;
    logic load;
    logic store;
    reg_addr_t dst;
    data_t result; // alu value or address.
    data_t store_data;
  } ex_res_t;

endpackage

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic clk,
  input  logic reset,
  input  payload_t d,
  input  logic [1:0] d_valid,
  input  logic [1:0] stall,
  input  logic [1:0] nop,
  output payload_t q,
  output logic [1:0] q_valid
);

  logic hold;

  // a slot stalled without a bubble pins the whole entry.
  assign hold = |(stall & ~nop);

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= '0;
    end else if (hold) begin
      q_valid <= q_valid & ~nop; // issued half drops out.
    end else begin
      q_valid <= d_valid & ~nop;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      q <= d;
    end
  end

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module inst_decoder import core_pkg::*; (
  input  instr_t instr,
  output dec_t dec
);

  logic [1:0] group;

  assign group = instr.opcode[`OP_CODE_BITS-1 -: 2];

  always_comb begin
    dec = '0;
    dec.instr = instr;
    case (group)
      2'b00: begin
        // rd from rs and rt.
        if (instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR}) begin
          dec.src_rs = 1'b1;
          dec.src_rt = 1'b1;
          dec.dst_rd = 1'b1;
        end
      end
      2'b01: begin
        if (instr.opcode inside {OP_ADDI, OP_ANDI}) begin
          dec.src_rs = 1'b1;
          dec.dst_rt = 1'b1;
        end
      end
      2'b10: begin
        if (instr.opcode == OP_LW) begin
          dec.src_rs = 1'b1;
          dec.dst_rt = 1'b1;
          dec.mem_read = 1'b1;
        end else if (instr.opcode == OP_SW) begin
          dec.src_rs = 1'b1;
          dec.src_rt = 1'b1; // store data.
          dec.mem_write = 1'b1;
        end
      end
      default: ; // jumps decode as nop.
    endcase
  end

endmodule

//--- verilog/hazard_detection_unit.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module hazard_detection_unit import core_pkg::*; (
  input  logic [1:0] id_ex_mem_read,
  input  reg_addr_t [1:0] id_ex_rt,
  input  logic first,
  input  dec_t dec0,
  input  dec_t dec1,
  input  logic [1:0] slot_valid,
  output pipe_mask_t stall0,
  output pipe_mask_t nop0,
  output pipe_mask_t stall1,
  output pipe_mask_t nop1
);

  localparam pipe_mask_t MASK_NONE = '0;
  localparam pipe_mask_t STALL_ALL = pipe_mask_t'({`NUM_PIPE_MASKS{1'b1}});
  localparam pipe_mask_t STALL_FRONT = '{pc: 1'b1, if_id: 1'b1, id_ex: 1'b0};
  localparam pipe_mask_t NOP_IF_ID = '{pc: 1'b0, if_id: 1'b1, id_ex: 1'b0};
  localparam pipe_mask_t NOP_ID_EX = '{pc: 1'b0, if_id: 1'b0, id_ex: 1'b1};

  dec_t older;
  dec_t younger;
  logic older_valid;
  logic younger_valid;
  logic load_use;
  logic pair_dep;
  pipe_mask_t stall_old;
  pipe_mask_t nop_old;
  pipe_mask_t stall_young;
  pipe_mask_t nop_young;

  function automatic logic reads_load(dec_t d, logic [1:0] rd, reg_addr_t [1:0] rt);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < 2; l++) begin
      if (rd[l] && ((d.src_rs && d.instr.rs == rt[l]) ||
                    (d.src_rt && d.instr.rt == rt[l]))) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic reg_addr_t dst_of(dec_t d);
    return d.dst_rd ? d.instr.rd : d.instr.rt;
  endfunction

  assign older = first ? dec0 : dec1;
  assign younger = first ? dec1 : dec0;
  assign older_valid = first ? slot_valid[0] : slot_valid[1];
  assign younger_valid = first ? slot_valid[1] : slot_valid[0];

  // load data is not forwarded, so any reader waits a cycle.
  assign load_use = (slot_valid[0] && reads_load(dec0, id_ex_mem_read, id_ex_rt)) ||
                    (slot_valid[1] && reads_load(dec1, id_ex_mem_read, id_ex_rt));

  always_comb begin
    pair_dep = 1'b0;
    if (older_valid && younger_valid && (older.dst_rt || older.dst_rd)) begin
      pair_dep = (younger.src_rs && younger.instr.rs == dst_of(older)) ||
                 (younger.src_rt && younger.instr.rt == dst_of(older)) ||
                 ((younger.dst_rt || younger.dst_rd) && dst_of(younger) == dst_of(older));
    end
  end

  always_comb begin
    stall_old = MASK_NONE;
    nop_old = MASK_NONE;
    stall_young = MASK_NONE;
    nop_young = MASK_NONE;
    if (load_use) begin
      stall_old = STALL_ALL;
      nop_old = NOP_ID_EX;
      stall_young = STALL_ALL;
      nop_young = NOP_ID_EX;
    end else if (pair_dep) begin
      stall_old = STALL_FRONT; // issues, then leaves if/id.
      nop_old = NOP_IF_ID;
      stall_young = STALL_ALL;
      nop_young = NOP_ID_EX;
    end
  end

  assign stall0 = first ? stall_old : stall_young;
  assign nop0 = first ? nop_old : nop_young;
  assign stall1 = first ? stall_young : stall_old;
  assign nop1 = first ? nop_young : nop_old;

endmodule

//--- verilog/exec_lane.sv
`timescale 1ns/1ps

module exec_lane import core_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  slot_t slot,
  input  data_t rs_data,
  input  data_t rt_data,
  input  wb_t [1:0] fwd,
  output ex_res_t res
);

  data_t op_a;
  data_t op_b;
  data_t imm;
  data_t alu;

  function automatic data_t pick(reg_addr_t src, data_t rf, wb_t [1:0] f);
    data_t v;
    v = rf;
    if (f[0].valid && f[0].dst == src) begin
      v = f[0].data;
    end
    if (f[1].valid && f[1].dst == src) begin
      v = f[1].data; // younger lane wins.
    end
    return v;
  endfunction

  assign op_a = pick(slot.dec.instr.rs, rs_data, fwd);
  assign op_b = pick(slot.dec.instr.rt, rt_data, fwd);
  assign imm = data_t'(slot.dec.instr.imm);

  always_comb begin
    case (slot.dec.instr.opcode)
      OP_ADD: alu = op_a + op_b;
      OP_SUB: alu = op_a - op_b;
      OP_AND: alu = op_a & op_b;
      OP_OR: alu = op_a | op_b;
      OP_ADDI, OP_LW, OP_SW: alu = op_a + imm;
      OP_ANDI: alu = op_a & imm;
      default: alu = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    res.load <= slot.dec.mem_read;
    res.store <= slot.dec.mem_write;
    res.dst <= slot.dec.dst_rd ? slot.dec.instr.rd : slot.dec.instr.rt;
    res.result <= alu;
    res.store_data <= op_b;
    if (reset) begin
      res.valid <= 1'b0;
    end else begin
      // nops carry nothing to writeback.
      res.valid <= slot.valid &&
                   (slot.dec.dst_rt || slot.dec.dst_rd || slot.dec.mem_write);
    end
  end

endmodule

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module writeback_stage import core_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  ex_res_t res0,
  input  ex_res_t res1,
  input  reg_addr_t [3:0] rd_addr,
  output data_t [3:0] rd_data,
  output wb_t wb0,
  output wb_t wb1
);

  data_t regs [`NUM_REGS];
  data_t dmem [`DMEM_WORDS];
  dmem_addr_t addr0;
  dmem_addr_t addr1;
  data_t load0;
  data_t load1;

  function automatic wb_t make_wb(ex_res_t r, data_t load_data);
    wb_t w;
    w.valid = r.valid && !r.store;
    w.dst = r.dst;
    w.data = r.load ? load_data : r.result;
    return w;
  endfunction

  assign addr0 = dmem_addr_t'(res0.result);
  assign addr1 = dmem_addr_t'(res1.result);

  assign load0 = dmem[addr0];
  // older store in lane 0 lands before the lane 1 load.
  assign load1 = (res0.valid && res0.store && addr0 == addr1) ? res0.store_data : dmem[addr1];

  assign wb0 = make_wb(res0, load0);
  assign wb1 = make_wb(res1, load1);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rd_data[i] = regs[rd_addr[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else begin
      if (wb0.valid) begin
        regs[wb0.dst] <= wb0.data;
      end
      if (wb1.valid) begin
        regs[wb1.dst] <= wb1.data; // lane 1 overrides.
      end
      if (res0.valid && res0.store) begin
        dmem[addr0] <= res0.store_data;
      end
      if (res1.valid && res1.store) begin
        dmem[addr1] <= res1.store_data;
      end
    end
  end

endmodule

//--- verilog/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core import core_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  input  pair_t in_pair,
  output logic in_ready,
  output wb_t wb0,
  output wb_t wb1
);

  pair_t if_id_q;
  logic [1:0] if_id_valid;
  dec_t dec0;
  dec_t dec1;
  slot_t in_slot0;
  slot_t in_slot1;
  pipe_mask_t stall0;
  pipe_mask_t nop0;
  pipe_mask_t stall1;
  pipe_mask_t nop1;
  slot_pair_t id_ex_d;
  slot_pair_t id_ex_q;
  logic [1:0] id_ex_d_valid;
  logic [1:0] id_ex_valid;
  logic [1:0] id_ex_stall;
  logic [1:0] id_ex_nop;
  logic [1:0] id_ex_mem_read;
  reg_addr_t [1:0] id_ex_rt;
  slot_t lane_slot [2];
  ex_res_t lane_res [2];
  wb_t [1:0] fwd;
  reg_addr_t [3:0] rd_addr;
  data_t [3:0] rd_data;

  assign in_ready = !(stall0.pc || stall1.pc);

  pipe_reg #(.payload_t(pair_t)) if_id (
    .clk, .reset,
    .d(in_pair), .d_valid({2{in_valid}}),
    .stall({stall1.if_id, stall0.if_id}), .nop({nop1.if_id, nop0.if_id}),
    .q(if_id_q), .q_valid(if_id_valid)
  );

  inst_decoder dec0_i (.instr(if_id_q.slot[0]), .dec(dec0));
  inst_decoder dec1_i (.instr(if_id_q.slot[1]), .dec(dec1));

  hazard_detection_unit hazard_i (
    .id_ex_mem_read, .id_ex_rt, .first(if_id_q.first),
    .dec0, .dec1, .slot_valid(if_id_valid),
    .stall0, .nop0, .stall1, .nop1
  );

  // slots are reordered by age on their way into id/ex.
  assign in_slot0 = '{valid: if_id_valid[0], dec: dec0};
  assign in_slot1 = '{valid: if_id_valid[1], dec: dec1};
  assign id_ex_d = if_id_q.first ? {in_slot1, in_slot0} : {in_slot0, in_slot1};
  assign id_ex_d_valid = if_id_q.first ? if_id_valid : {if_id_valid[0], if_id_valid[1]};
  assign id_ex_stall = if_id_q.first ? {stall1.id_ex, stall0.id_ex} : {stall0.id_ex, stall1.id_ex};
  assign id_ex_nop = if_id_q.first ? {nop1.id_ex, nop0.id_ex} : {nop0.id_ex, nop1.id_ex};

  pipe_reg #(.payload_t(slot_pair_t)) id_ex (
    .clk, .reset,
    .d(id_ex_d), .d_valid(id_ex_d_valid),
    .stall(id_ex_stall), .nop(id_ex_nop),
    .q(id_ex_q), .q_valid(id_ex_valid)
  );

  for (genvar i = 0; i < 2; i++) begin : g_lane
    assign lane_slot[i] = '{valid: id_ex_valid[i], dec: id_ex_q[i].dec};
    assign id_ex_mem_read[i] = id_ex_valid[i] && id_ex_q[i].dec.mem_read;
    assign id_ex_rt[i] = id_ex_q[i].dec.instr.rt;
    assign rd_addr[2*i] = id_ex_q[i].dec.instr.rs;
    assign rd_addr[2*i+1] = id_ex_q[i].dec.instr.rt;
    // only alu results feed back.
    assign fwd[i] = '{valid: lane_res[i].valid && !lane_res[i].load && !lane_res[i].store,
                      dst: lane_res[i].dst, data: lane_res[i].result};

    exec_lane lane_i (
      .clk, .reset, .slot(lane_slot[i]),
      .rs_data(rd_data[2*i]), .rt_data(rd_data[2*i+1]),
      .fwd, .res(lane_res[i])
    );
  end

  writeback_stage wb_i (
    .clk, .reset,
    .res0(lane_res[0]), .res1(lane_res[1]),
    .rd_addr, .rd_data, .wb0, .wb1
  );

endmodule

//--- testbench/core_checker.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module core_checker import core_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  input  logic in_ready,
  input  pair_t in_pair,
  input  wb_t wb0,
  input  wb_t wb1,
  output int errors,
  output int writes,
  output int pending
);

  data_t regs_m [`NUM_REGS];
  data_t mem_m [`DMEM_WORDS];
  wb_t exp_q [$];

  initial begin
    errors = 0;
    writes = 0;
    pending = 0;
  end

  task automatic expect_write(reg_addr_t dst, data_t val);
    wb_t e;
    e.valid = 1'b1;
    e.dst = dst;
    e.data = val;
    regs_m[dst] = val;
    exp_q.push_back(e);
  endtask

  // one instruction of the sequential program.
  task automatic run_instr(instr_t i);
    data_t a;
    data_t b;
    data_t imm;
    dmem_addr_t addr;
    a = regs_m[i.rs];
    b = regs_m[i.rt];
    imm = {8'h00, i.imm};
    addr = dmem_addr_t'(a + imm);
    case (i.opcode)
      OP_ADD: expect_write(i.rd, a + b);
      OP_SUB: expect_write(i.rd, a - b);
      OP_AND: expect_write(i.rd, a & b);
      OP_OR: expect_write(i.rd, a | b);
      OP_ADDI: expect_write(i.rt, a + imm);
      OP_ANDI: expect_write(i.rt, a & imm);
      OP_LW: expect_write(i.rt, mem_m[addr]);
      OP_SW: mem_m[addr] = b;
      default: ;
    endcase
  endtask

  task automatic check_lane(string name, wb_t w);
    wb_t e;
    if (w.valid) begin
      writes++;
      if (exp_q.size() == 0) begin
        $display("%s wrote r%0d while no write was expected", name, w.dst);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (w.dst !== e.dst) begin
          $display("Fail %s.dst: expected %h, got %h", name, e.dst, w.dst);
          errors++;
        end
        if (w.data !== e.data) begin
          $display("Fail %s.data: expected %h, got %h", name, e.data, w.data);
          errors++;
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (reset) begin
      for (int r = 0; r < `NUM_REGS; r++) begin
        regs_m[r] = '0;
      end
      for (int m = 0; m < `DMEM_WORDS; m++) begin
        mem_m[m] = '0;
      end
      exp_q.delete();
    end else begin
      check_lane("wb0", wb0); // older lane first.
      check_lane("wb1", wb1);
      if (in_valid && in_ready) begin
        run_instr(in_pair.first ? in_pair.slot[0] : in_pair.slot[1]);
        run_instr(in_pair.first ? in_pair.slot[1] : in_pair.slot[0]);
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- testbench/core_props.sv
`timescale 1ns/1ps

module core_props import core_pkg::*; (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic in_ready,
  input pair_t in_pair,
  input wb_t wb0,
  input wb_t wb1,
  input pipe_mask_t stall0,
  input pipe_mask_t stall1,
  input pair_t if_id_q
);

  a_hold_input: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_pair))
    else $error("input pair changed while waiting for ready");

  a_no_wb_in_reset: assert property (@(posedge clk)
    reset |=> !wb0.valid && !wb1.valid)
    else $error("writeback valid while in reset");

  // a stalled front end keeps its pair.
  a_if_id_holds: assert property (@(posedge clk) disable iff (reset)
    (stall0.if_id || stall1.if_id) |=> $stable(if_id_q))
    else $error("if/id entry changed while stalled");

endmodule

bind dual_issue_core core_props props_i (
  .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready), .in_pair(in_pair),
  .wb0(wb0), .wb1(wb1), .stall0(stall0), .stall1(stall1), .if_id_q(if_id_q)
);

//--- testbench/dual_issue_core_tb.sv
`timescale 1ns/1ps

module dual_issue_core_tb import core_pkg::*; ();

  localparam int TOTAL_PAIRS = 168;
  localparam int CYCLE_LIMIT = TOTAL_PAIRS * 3 + 50;

  logic clk;
  logic reset;
  logic in_valid;
  logic in_ready;
  pair_t in_pair;
  wb_t wb0;
  wb_t wb1;
  int chk_errors;
  int chk_writes;
  int chk_pending;
  int cycle_count;
  int tb_errors;
  int tests_passed;
  int tests_failed;
  int err_mark;

  dual_issue_core dut_i (.clk, .reset, .in_valid, .in_pair, .in_ready, .wb0, .wb1);

  core_checker checker_i (
    .clk, .reset, .in_valid, .in_ready, .in_pair, .wb0, .wb1,
    .errors(chk_errors), .writes(chk_writes), .pending(chk_pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic instr_t make_instr(logic [5:0] op, int rs, int rt, int rd);
    instr_t i;
    i.opcode = op;
    i.rs = reg_addr_t'(rs);
    i.rt = reg_addr_t'(rt);
    i.rd = reg_addr_t'(rd);
    i.imm = 8'($urandom);
    return i;
  endfunction

  // registers drawn from lo..lo+3.
  function automatic instr_t rand_alu(int lo);
    logic [5:0] op;
    case ($urandom_range(5, 0))
      0: op = OP_ADD;
      1: op = OP_SUB;
      2: op = OP_AND;
      3: op = OP_OR;
      4: op = OP_ADDI;
      default: op = OP_ANDI;
    endcase
    return make_instr(op, lo + $urandom_range(3, 0), lo + $urandom_range(3, 0),
                      lo + $urandom_range(3, 0));
  endfunction

  function automatic instr_t rand_any();
    logic [5:0] op;
    case ($urandom_range(10, 0))
      0: op = OP_NOP;
      1: op = OP_ADD;
      2: op = OP_SUB;
      3: op = OP_AND;
      4: op = OP_OR;
      5: op = OP_ADDI;
      6: op = OP_ANDI;
      7, 8: op = OP_LW;
      9: op = OP_SW;
      default: op = 6'h30; // jump group, no effect.
    endcase
    return make_instr(op, $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(7, 0));
  endfunction

  function automatic reg_addr_t dst_of(instr_t i);
    return (i.opcode[5:4] == 2'b00) ? i.rd : i.rt;
  endfunction

  function automatic bit is_writer(instr_t i);
    return i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_ANDI, OP_LW};
  endfunction

  function automatic pair_t place(instr_t older, instr_t younger, logic first);
    pair_t p;
    p.first = first;
    p.slot[0] = first ? older : younger;
    p.slot[1] = first ? younger : older;
    return p;
  endfunction

  task automatic send_pair(pair_t p);
    in_valid = 1'b1;
    in_pair = p;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic close_test(string name);
    int errs;
    while (chk_pending != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    errs = chk_errors + tb_errors - err_mark;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %-28s %s (%0d errors)", name, (errs == 0) ? "passed" : "failed", errs);
    err_mark = chk_errors + tb_errors;
  endtask

  initial begin
    instr_t a;
    instr_t b;
    int writers;
    int seen_mark;
    void'($urandom(32'h4b80d74c));
    reset = 1'b1;
    in_valid = 1'b0;
    in_pair = '0;
    cycle_count = 0;
    tb_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    err_mark = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int n = 0; n < 40; n++) begin
      send_pair(place(rand_alu(0), rand_alu(4), 1'($urandom)));
    end
    close_test("independent alu pairs");

    for (int n = 0; n < 40; n++) begin
      a = rand_alu(0);
      b = rand_alu(0);
      case ($urandom_range(2, 0))
        0: b.rs = dst_of(a);
        1: b.rt = dst_of(a); // read or overwrite, by op.
        default: begin
          b.rd = dst_of(a);
          b.rt = dst_of(a);
        end
      endcase
      send_pair(place(a, b, n[0]));
    end
    close_test("intra-pair dependency");

    for (int n = 0; n < 8; n++) begin
      a = make_instr(OP_SW, 1, 2, 0);
      b = make_instr(OP_SW, 1, 3, 0);
      b.imm = a.imm; // same address twice.
      send_pair(place(a, b, 1'($urandom)));
      a = make_instr(OP_LW, 1, 4, 0);
      a.imm = b.imm;
      b = make_instr(OP_ADD, 4, $urandom_range(7, 0), $urandom_range(7, 0));
      send_pair(place(a, b, 1'($urandom)));
      send_pair(place(rand_alu(0), make_instr(OP_LW, $urandom_range(7, 0), 2, 0),
                      1'($urandom)));
    end
    close_test("load-use and store round trip");

    writers = 0;
    seen_mark = chk_writes;
    for (int n = 0; n < 60; n++) begin
      a = rand_any();
      b = rand_any();
      writers += is_writer(a) + is_writer(b);
      send_pair(place(a, b, 1'($urandom)));
      if ($urandom_range(3, 0) == 0) begin
        repeat ($urandom_range(3, 1)) @(posedge clk);
        #1;
      end
    end
    while (chk_pending != 0) begin
      @(posedge clk);
    end
    #1;
    if (chk_writes - seen_mark != writers) begin
      $display("%0d register writes were sent but %0d came back",
               writers, chk_writes - seen_mark);
      tb_errors++;
    end
    close_test("random back-pressure");

    send_pair(place(rand_alu(0), rand_alu(4), 1'b1));
    send_pair(place(rand_alu(0), rand_alu(4), 1'b0));
    // reset lands with both pairs still in flight.
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    if (in_ready !== 1'b1) begin
      $display("Fail in_ready: expected %h, got %h", 1'b1, in_ready);
      tb_errors++;
    end
    send_pair(place(make_instr(OP_ADD, 2, 3, 1), make_instr(OP_OR, 5, 6, 4), 1'b1));
    send_pair(place(make_instr(OP_SUB, 7, 0, 2), make_instr(OP_LW, 3, 5, 0), 1'b0));
    close_test("reset clears state");

    $display("tests: %0d passed, %0d failed, %0d writes checked, %0d errors",
             tests_passed, tests_failed, chk_writes, chk_errors + tb_errors);
    if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- dual_issue_core.f
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_reg.sv
verilog/inst_decoder.sv
verilog/hazard_detection_unit.sv
verilog/exec_lane.sv
verilog/writeback_stage.sv
verilog/dual_issue_core.sv
testbench/core_checker.sv
testbench/core_props.sv
testbench/dual_issue_core_tb.sv

//--- Makefile
TOP = dual_issue_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dual_issue_core.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
